// ==== team_pkg.sv ====
/*
 * Checksum tile shared definitions
 * Bus widths, CRC-32 polynomial and the Fletcher-32 result layout
 */

package team_pkg;

    // Wishbone data and byte address widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int SEL_W  = DATA_W / 8;  // One select bit per byte lane

    // Reflected form of 0x04C11DB7, LSB first shifting
    localparam logic [DATA_W-1:0] CRC_POLY = 32'hEDB88320;

    // Fletcher-32 running sums
    // s2 sits in the upper half, as in the usual checksum word
    typedef struct packed {
        logic [15:0] s2;  // Sum of sums
        logic [15:0] s1;  // Sum of data halves
    } fletcher_t;

endpackage

// ==== cpu_bus_if.sv ====
/*
 * Request bus between the checksum core and the Wishbone manager
 * One read or write pulse at a time, busy until the acknowledge is seen
 */

`timescale 1ns/1ps

interface cpu_bus_if;
    import team_pkg::*;

    logic [ADDR_W-1:0] adr;   // Byte address
    logic [DATA_W-1:0] wdat;  // Write data
    logic [SEL_W-1:0]  sel;   // Byte lanes
    logic              write; // One cycle write pulse
    logic              read;  // One cycle read pulse
    logic [DATA_W-1:0] rdat;  // Read data, valid once busy drops
    logic              busy;  // Cycle open on Wishbone

    // Core side
    modport requester (
        output adr, wdat, sel, write, read,
        input  rdat, busy
    );

    // Bus master side
    modport manager (
        input  adr, wdat, sel, write, read,
        output rdat, busy
    );

endinterface

// ==== wishbone_manager.sv ====
/*
 * Wishbone classic manager
 * Turns single read and write pulses into one bus cycle each
 */

`timescale 1ns/1ps

module wishbone_manager (
    input  logic                          clk,
    input  logic                          rst,
    cpu_bus_if.manager                    bus,
    input  logic [team_pkg::DATA_W-1:0]   DAT_I,
    input  logic                          ACK_I,
    output logic [team_pkg::ADDR_W-1:0]   ADR_O,
    output logic [team_pkg::DATA_W-1:0]   DAT_O,
    output logic [team_pkg::SEL_W-1:0]    SEL_O,
    output logic                          WE_O,
    output logic                          STB_O,
    output logic                          CYC_O
);

    typedef enum logic {
        IDLE,
        CYCLE
    } state_t;

    state_t state;
    logic   launch;  // Request taken this edge
    logic   finish;  // Acknowledge seen this edge

    assign launch = (state == IDLE) && (bus.read || bus.write);
    assign finish = (state == CYCLE) && ACK_I;

    // Control
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            WE_O  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (launch) begin
                        state <= CYCLE;
                        WE_O  <= bus.write;  // Held for the whole cycle
                    end
                end
                CYCLE: begin
                    if (ACK_I) begin
                        state <= IDLE;       // No retry, no error path
                        WE_O  <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address, data and select latched once per request
    always_ff @(posedge clk) begin
        if (launch) begin
            ADR_O <= bus.adr;
            DAT_O <= bus.wdat;
            SEL_O <= bus.sel;
        end
        if (finish && !WE_O)
            bus.rdat <= DAT_I;  // Read return captured on ACK
    end

    // CYC and STB open and close together
    assign CYC_O    = (state == CYCLE);
    assign STB_O    = (state == CYCLE);
    assign bus.busy = (state == CYCLE);  // Drops the cycle after ACK

endmodule

// ==== fletcher_unit.sv ====
/*
 * Fletcher-32 accumulator
 * Folds the low then the high 16-bit half of each word, modulo 65535
 */

`timescale 1ns/1ps

module fletcher_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        upd,
    input  logic [team_pkg::DATA_W-1:0] word,
    output team_pkg::fletcher_t         sum
);

    logic [15:0] s1_lo;  // After the low half
    logic [15:0] s2_lo;
    logic [15:0] s1_hi;  // After the high half
    logic [15:0] s2_hi;

    // Ones complement style add, 65535 folds to zero
    function automatic logic [15:0] add_mod(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] t;
        t = {1'b0, a} + {1'b0, b};
        if (t >= 17'd65535)
            t = t - 17'd65535;
        return t[15:0];
    endfunction

    // Two chained steps per word
    always_comb begin
        s1_lo = add_mod(sum.s1, word[15:0]);
        s2_lo = add_mod(sum.s2, s1_lo);
        s1_hi = add_mod(s1_lo, word[31:16]);
        s2_hi = add_mod(s2_lo, s1_hi);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else if (clear) begin
            sum <= '0;      // New block
        end else if (upd) begin
            sum.s1 <= s1_hi;
            sum.s2 <= s2_hi;
        end
    end

endmodule

// ==== crc32_unit.sv ====
/*
 * CRC-32 accumulator, reflected form
 * Shifts 32 data bits LSB first per update, output carries the final XOR
 */

`timescale 1ns/1ps

module crc32_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        upd,
    input  logic [team_pkg::DATA_W-1:0] word,
    output logic [team_pkg::DATA_W-1:0] crc
);
    import team_pkg::*;

    logic [DATA_W-1:0] crc_q;
    logic [DATA_W-1:0] crc_next;

    // Bitwise LFSR, byte 0 goes in first since bits run LSB first
    function automatic logic [DATA_W-1:0] crc_step(input logic [DATA_W-1:0] c,
                                                   input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] r;
        r = c;
        for (int i = 0; i < DATA_W; i++) begin
            if (r[0] ^ d[i])
                r = (r >> 1) ^ CRC_POLY;
            else
                r = r >> 1;
        end
        return r;
    endfunction

    assign crc_next = crc_step(crc_q, word);

    always_ff @(posedge clk) begin
        if (rst || clear)
            crc_q <= '1;        // Standard preset
        else if (upd)
            crc_q <= crc_next;
    end

    assign crc = ~crc_q;  // Final XOR

endmodule

// ==== checksum_core.sv ====
/*
 * Block checksum core
 * Reads a block of words, runs Fletcher-32 and CRC-32 on it and
 * writes both results right after the block
 */

`timescale 1ns/1ps

module checksum_core #(
    parameter int COUNT_W = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         en,
    input  logic [33:0]  gpio_in,
    output logic [33:0]  gpio_out,
    output logic [33:0]  gpio_oeb,
    output logic [63:0]  result,
    cpu_bus_if.requester bus
);
    import team_pkg::*;

    // GPIO fields
    localparam int START_BIT = 32;
    localparam int WADR_MSB  = 31;
    localparam int WADR_LSB  = 8;

    typedef enum logic [2:0] {
        IDLE,
        ISSUE_RD,
        WAIT_RD,
        WR_FL,
        WR_CRC,
        WAIT_WR,
        DONE
    } state_t;

    state_t             state;
    logic               start_q;     // Start pin, last cycle
    logic               start_edge;
    logic               accept;      // Job taken this edge
    logic               bus_idle;    // No request pending or open
    logic               upd;         // Read word returned
    logic               rd_q;
    logic               wr_q;
    logic               job_busy;
    logic               job_done;
    logic [ADDR_W-1:0]  base;
    logic [ADDR_W-1:0]  addr;        // Next bus address
    logic [COUNT_W-1:0] remaining;   // Zero means full range
    fletcher_t          fl_sum;
    logic [DATA_W-1:0]  crc_val;

    assign start_edge = gpio_in[START_BIT] & ~start_q;
    assign accept     = en && start_edge && (state == IDLE || state == DONE);
    assign bus_idle   = !rd_q && !wr_q && !bus.busy;
    assign upd        = (state == WAIT_RD) && bus_idle;

    // Word address pins map to byte address bits 25..2
    assign base = {{(ADDR_W - 26){1'b0}}, gpio_in[WADR_MSB:WADR_LSB], 2'b00};

    // Sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            start_q <= 1'b0;
            rd_q    <= 1'b0;
            wr_q    <= 1'b0;
        end else begin
            start_q <= gpio_in[START_BIT];
            rd_q    <= 1'b0;  // Pulses last one cycle
            wr_q    <= 1'b0;
            case (state)
                IDLE, DONE: begin
                    if (accept)
                        state <= ISSUE_RD;
                end
                ISSUE_RD: begin
                    if (!en) begin
                        state <= IDLE;
                    end else if (bus_idle) begin
                        rd_q  <= 1'b1;
                        state <= WAIT_RD;
                    end
                end
                WAIT_RD: begin
                    if (bus_idle) begin
                        if (!en)
                            state <= IDLE;     // Abort after the open cycle
                        else if (remaining == COUNT_W'(1))
                            state <= WR_FL;    // Last word in
                        else
                            state <= ISSUE_RD;
                    end
                end
                WR_FL: begin
                    if (!en) begin
                        state <= IDLE;
                    end else if (bus_idle) begin
                        wr_q  <= 1'b1;
                        state <= WR_CRC;
                    end
                end
                WR_CRC: begin
                    // Wait out the Fletcher write first
                    if (bus_idle) begin
                        if (!en) begin
                            state <= IDLE;
                        end else begin
                            wr_q  <= 1'b1;
                            state <= WAIT_WR;
                        end
                    end
                end
                WAIT_WR: begin
                    if (bus_idle)
                        state <= en ? DONE : IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address walk and word count
    always_ff @(posedge clk) begin
        if (accept) begin
            addr      <= base;
            remaining <= gpio_in[COUNT_W-1:0];
        end else if (upd) begin
            addr      <= addr + ADDR_W'(4);        // Ends at base + 4*count
            remaining <= remaining - COUNT_W'(1);
        end else if (state == WR_CRC && bus_idle && en) begin
            addr      <= addr + ADDR_W'(4);        // CRC slot
        end
    end

    // Last results for the LA pins
    always_ff @(posedge clk) begin
        if (rst)
            result <= '0;
        else if (state == WR_FL)
            result <= {fl_sum, crc_val};
    end

    fletcher_unit u_fletcher (
        .clk   (clk),
        .rst   (rst),
        .clear (accept),
        .upd   (upd),
        .word  (bus.rdat),
        .sum   (fl_sum)
    );

    crc32_unit u_crc (
        .clk   (clk),
        .rst   (rst),
        .clear (accept),
        .upd   (upd),
        .word  (bus.rdat),
        .crc   (crc_val)
    );

    // Request side of the bus
    assign bus.read  = rd_q;
    assign bus.write = wr_q;
    assign bus.adr   = addr;
    assign bus.sel   = '1;  // Full words only
    assign bus.wdat  = (state == WR_CRC) ? fl_sum : crc_val;  // Fletcher goes first

    // Status pins
    assign job_done = (state == DONE);
    assign job_busy = (state != IDLE) && (state != DONE);
    assign gpio_out = {32'b0, job_busy, job_done};
    assign gpio_oeb = {{32{1'b1}}, 2'b00};  // Only bits 0 and 1 driven

endmodule

// ==== team_03.sv ====
/*
 * team_03 tile top level
 * Block checksum engine on the management core Wishbone port
 */

`timescale 1ns/1ps

module team_03 #(
    parameter int COUNT_W = 8  // Word count field width
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          en,

    // Logic analyzer, only the output side is used
    input  logic [127:0]                  la_data_in,
    output logic [127:0]                  la_data_out,
    input  logic [127:0]                  la_oenb,

    // Breakout board pins
    input  logic [33:0]                   gpio_in,
    output logic [33:0]                   gpio_out,
    output logic [33:0]                   gpio_oeb,  // Active low

    // Wishbone manager port
    output logic [team_pkg::ADDR_W-1:0]   ADR_O,
    output logic [team_pkg::DATA_W-1:0]   DAT_O,
    output logic [team_pkg::SEL_W-1:0]    SEL_O,
    output logic                          WE_O,
    output logic                          STB_O,
    output logic                          CYC_O,
    input  logic [team_pkg::DATA_W-1:0]   DAT_I,
    input  logic                          ACK_I
);

    logic [63:0] result;  // Fletcher high, CRC low

    cpu_bus_if bus ();

    checksum_core #(
        .COUNT_W (COUNT_W)
    ) core (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oeb (gpio_oeb),
        .result   (result),
        .bus      (bus.requester)
    );

    wishbone_manager wb (
        .clk   (clk),
        .rst   (rst),
        .bus   (bus.manager),
        .DAT_I (DAT_I),
        .ACK_I (ACK_I),
        .ADR_O (ADR_O),
        .DAT_O (DAT_O),
        .SEL_O (SEL_O),
        .WE_O  (WE_O),
        .STB_O (STB_O),
        .CYC_O (CYC_O)
    );

    assign la_data_out = {64'b0, result};  // Upper LA bits unused

endmodule

// ==== tb_wb_memory.sv ====
/*
 * Wishbone classic slave memory for the team_03 testbench
 * 4096 words, optional random acknowledge delay, random whole-memory fill
 */

`timescale 1ns/1ps

module tb_wb_memory (
    input  logic        clk,
    input  logic        rst,
    input  logic        fill,        // Load random words everywhere
    input  logic        rand_delay,  // 0 to 3 wait cycles per access
    input  logic [31:0] adr,
    input  logic [31:0] dat_w,
    input  logic [3:0]  sel,
    input  logic        we,
    input  logic        stb,
    input  logic        cyc,
    output logic [31:0] dat_r,
    output logic        ack
);

    localparam int DEPTH = 4096;

    logic [31:0] mem [DEPTH];
    logic [11:0] idx;        // Word index, byte address bits 13..2
    logic [31:0] lane_mask;
    logic        pending;    // Delay already drawn for this access
    int          wait_left;
    int          delay;

    assign idx       = adr[13:2];
    assign lane_mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};

    always @(posedge clk) begin
        if (rst) begin
            ack       <= 1'b0;
            pending   <= 1'b0;
            wait_left <= 0;
        end else if (fill) begin
            for (int i = 0; i < DEPTH; i++)
                mem[12'(i)] <= $urandom;
        end else if (ack) begin
            ack <= 1'b0;  // Single cycle ACK
        end else if (cyc && stb) begin
            // First sight of the access draws the delay
            delay = pending ? wait_left : (rand_delay ? int'($urandom_range(3, 0)) : 0);
            if (delay == 0) begin
                ack     <= 1'b1;
                pending <= 1'b0;
                if (we)
                    mem[idx] <= (mem[idx] & ~lane_mask) | (dat_w & lane_mask);
                else
                    dat_r <= mem[idx];
            end else begin
                pending   <= 1'b1;
                wait_left <= delay - 1;
            end
        end
    end

endmodule

// ==== tb_team_03.sv ====
/*
 * Testbench for the team_03 checksum tile
 * Runs a table of block jobs against a Wishbone memory model and checks
 * written results, LA outputs, GPIO status and the bus handshake
 */

`timescale 1ns/1ps

module tb_team_03;
    import team_pkg::*;

    localparam int ROWS = 7;

    typedef struct packed {
        logic [23:0] word_adr;  // Block start, word address
        logic [7:0]  count;     // 0 means 256 words
        logic        en_on;
        logic        rand_ack;  // Random ACK delay
        logic        refill;    // New memory contents first
    } job_t;

    localparam job_t JOBS [ROWS] = '{
        '{24'h000040, 8'd3, 1'b0, 1'b0, 1'b1},  // en low, no job
        '{24'h000010, 8'd1, 1'b1, 1'b0, 1'b1},
        '{24'h000123, 8'd5, 1'b1, 1'b0, 1'b1},
        '{24'h000123, 8'd5, 1'b1, 1'b1, 1'b0},  // Same block under back-pressure
        '{24'h000200, 8'd0, 1'b1, 1'b0, 1'b1},
        '{24'h000200, 8'd0, 1'b1, 1'b1, 1'b0},
        '{24'h000ff0, 8'd7, 1'b1, 1'b1, 1'b1}
    };

    logic         clk = 1'b0;
    logic         rst;
    logic         en;
    logic [127:0] la_data_in;
    logic [127:0] la_data_out;
    logic [127:0] la_oenb;
    logic [33:0]  gpio_in;
    logic [33:0]  gpio_out;
    logic [33:0]  gpio_oeb;
    logic [31:0]  ADR_O;
    logic [31:0]  DAT_O;
    logic [31:0]  DAT_I;
    logic [3:0]   SEL_O;
    logic         WE_O;
    logic         STB_O;
    logic         CYC_O;
    logic         ACK_I;
    logic         fill;
    logic         rand_delay;

    // Job context, set before each start
    logic [31:0]  job_base;
    int           job_words;
    int           rd_mark;
    int           wr_mark;
    logic [31:0]  last_fl;
    logic [31:0]  last_crc;

    // Bus monitor state
    logic         prev_cyc;
    logic         prev_open;   // Cycle open and not acknowledged
    logic         prev_ack;
    logic         prev_we;
    logic [31:0]  prev_adr;
    logic [31:0]  prev_dat;
    int           rd_count;
    int           wr_count;
    int           cyc_count;

    int           cycle_count = 0;
    int           cycle_limit;

    always #50 clk = ~clk;

    team_03 #(
        .COUNT_W (8)
    ) team_03_inst (
        .clk         (clk),
        .rst         (rst),
        .en          (en),
        .la_data_in  (la_data_in),
        .la_data_out (la_data_out),
        .la_oenb     (la_oenb),
        .gpio_in     (gpio_in),
        .gpio_out    (gpio_out),
        .gpio_oeb    (gpio_oeb),
        .ADR_O       (ADR_O),
        .DAT_O       (DAT_O),
        .SEL_O       (SEL_O),
        .WE_O        (WE_O),
        .STB_O       (STB_O),
        .CYC_O       (CYC_O),
        .DAT_I       (DAT_I),
        .ACK_I       (ACK_I)
    );

    tb_wb_memory mem_inst (
        .clk        (clk),
        .rst        (rst),
        .fill       (fill),
        .rand_delay (rand_delay),
        .adr        (ADR_O),
        .dat_w      (DAT_O),
        .sel        (SEL_O),
        .we         (WE_O),
        .stb        (STB_O),
        .cyc        (CYC_O),
        .dat_r      (DAT_I),
        .ack        (ACK_I)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    function automatic int words_of(input job_t job);
        return (job.count == 8'd0) ? 256 : int'(job.count);
    endfunction

    // Fletcher-32, low half then high half, both sums modulo 65535
    function automatic logic [31:0] ref_fletcher(input int first, input int words);
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] w;
        s1 = 32'd0;
        s2 = 32'd0;
        for (int i = 0; i < words; i++) begin
            w  = mem_inst.mem[12'(first + i)];
            s1 = (s1 + {16'd0, w[15:0]}) % 32'd65535;
            s2 = (s2 + s1) % 32'd65535;
            s1 = (s1 + {16'd0, w[31:16]}) % 32'd65535;
            s2 = (s2 + s1) % 32'd65535;
        end
        return {s2[15:0], s1[15:0]};
    endfunction

    // Standard CRC-32, bytewise, lowest byte of each word first
    function automatic logic [31:0] ref_crc32(input int first, input int words);
        logic [31:0] c;
        logic [31:0] w;
        c = 32'hffffffff;
        for (int i = 0; i < words; i++) begin
            w = mem_inst.mem[12'(first + i)];
            for (int b = 0; b < 4; b++) begin
                c = c ^ ((w >> (8 * b)) & 32'h000000ff);
                for (int k = 0; k < 8; k++)
                    c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic fill_memory();
        @(posedge clk);
        fill <= 1'b1;
        @(posedge clk);
        fill <= 1'b0;
        @(negedge clk);  // New contents visible
    endtask

    task automatic run_job(input job_t job);
        logic [31:0] exp_fl;
        logic [31:0] exp_crc;
        logic [31:0] got_fl;
        logic [31:0] got_crc;
        int          words;
        int          first;
        int          cyc_before;
        words = words_of(job);
        first = int'(job.word_adr);
        if (job.refill)
            fill_memory();
        exp_fl     = ref_fletcher(first, words);
        exp_crc    = ref_crc32(first, words);
        job_base   = {6'b0, job.word_adr, 2'b00};
        job_words  = words;
        rd_mark    = rd_count;
        wr_mark    = wr_count;
        cyc_before = cyc_count;

        // Start level high, address and count alongside
        @(posedge clk);
        en         <= job.en_on;
        rand_delay <= job.rand_ack;
        gpio_in    <= {1'b0, 1'b1, job.word_adr, job.count};
        @(posedge clk);
        @(negedge clk);
        if (!job.en_on) begin
            repeat (20) @(posedge clk);
            @(negedge clk);
            check_value(32'(cyc_count - cyc_before), 32'd0, "bus cycle with en low");
            check_value(32'(gpio_out[0]), 32'd0, "done set with en low");
            check_value(32'(gpio_out[1]), 32'd0, "busy set with en low");
            @(posedge clk);
            gpio_in[32] <= 1'b0;
            return;
        end
        check_value(32'(gpio_out[0]), 32'd0, "done not cleared by start");
        check_value(32'(gpio_out[1]), 32'd1, "busy not set after start");
        @(posedge clk);
        gpio_in[32] <= 1'b0;

        while (gpio_out[0] !== 1'b1)
            @(negedge clk);
        got_fl  = mem_inst.mem[12'(first + words)];
        got_crc = mem_inst.mem[12'(first + words + 1)];
        check_value(got_fl, exp_fl, "Fletcher word written back");
        check_value(got_crc, exp_crc, "CRC word written back");
        check_value(la_data_out[63:32], exp_fl, "Fletcher on la_data_out");
        check_value(la_data_out[31:0], exp_crc, "CRC on la_data_out");
        check_value(32'(la_data_out[127:64] != 64'd0), 32'd0, "upper LA bits not zero");
        check_value(32'(rd_count - rd_mark), 32'(words), "number of reads");
        check_value(32'(wr_count - wr_mark), 32'd2, "number of writes");
        check_value(32'(gpio_out[1]), 32'd0, "busy still high at done");
        if (!job.refill) begin
            check_value(got_fl, last_fl, "Fletcher differs under back-pressure");
            check_value(got_crc, last_crc, "CRC differs under back-pressure");
        end
        last_fl  = got_fl;
        last_crc = got_crc;
    endtask

    // Handshake and address order, sampled at the clock edge
    always @(posedge clk) begin
        if (rst) begin
            prev_cyc  <= 1'b0;
            prev_open <= 1'b0;
            prev_ack  <= 1'b0;
            rd_count  <= 0;
            wr_count  <= 0;
            cyc_count <= 0;
        end else begin
            if (CYC_O)
                check_value(32'(STB_O), 32'd1, "STB_O low inside a bus cycle");
            if (prev_ack)
                check_value(32'(CYC_O), 32'd0, "CYC_O held after ACK_I");
            if (prev_open) begin
                check_value(32'(CYC_O), 32'd1, "CYC_O dropped before ACK_I");
                check_value(ADR_O, prev_adr, "ADR_O changed before ACK_I");
                check_value(DAT_O, prev_dat, "DAT_O changed before ACK_I");
                check_value(32'(WE_O), 32'(prev_we), "WE_O changed before ACK_I");
            end
            if (CYC_O && !prev_cyc) begin
                cyc_count <= cyc_count + 1;
                check_value(32'(SEL_O), 32'hf, "SEL_O not all ones");
                if (WE_O) begin
                    check_value(ADR_O, job_base + 32'(4 * (job_words + wr_count - wr_mark)),
                                "write address");
                    wr_count <= wr_count + 1;
                end else begin
                    check_value(ADR_O, job_base + 32'(4 * (rd_count - rd_mark)),
                                "read address out of order");
                    rd_count <= rd_count + 1;
                end
            end
            prev_cyc  <= CYC_O;
            prev_open <= CYC_O && !ACK_I;
            prev_ack  <= CYC_O && ACK_I;
            prev_adr  <= ADR_O;
            prev_dat  <= DAT_O;
            prev_we   <= WE_O;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, a job never reached done", cycle_count);
            $display("FAIL: see errors above");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        rst        <= 1'b1;
        en         <= 1'b0;
        gpio_in    <= '0;
        la_data_in <= '0;
        la_oenb    <= '1;
        fill       <= 1'b0;
        rand_delay <= 1'b0;
        void'($urandom(32'hd517));
        job_base  = '0;
        job_words = 0;
        rd_mark   = 0;
        wr_mark   = 0;
        last_fl   = '0;
        last_crc  = '0;
        cycle_limit = 200;
        for (int r = 0; r < ROWS; r++)
            cycle_limit += (words_of(JOBS[r]) + 2) * 8;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value(32'(CYC_O), 32'd0, "CYC_O after reset");
        check_value(32'(STB_O), 32'd0, "STB_O after reset");
        check_value(32'(WE_O), 32'd0, "WE_O after reset");
        check_value(32'(gpio_out[1:0]), 32'd0, "done or busy after reset");
        check_value(32'(gpio_oeb[1:0]), 32'd0, "gpio_oeb on status bits");
        check_value(gpio_oeb[33:2], 32'hffffffff, "gpio_oeb on unused pins");

        for (int r = 0; r < ROWS; r++)
            run_job(JOBS[r]);

        repeat (2) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== sources.f ====
team_pkg.sv
cpu_bus_if.sv
wishbone_manager.sv
fletcher_unit.sv
crc32_unit.sv
checksum_core.sv
team_03.sv
tb_wb_memory.sv
tb_team_03.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the team_03 testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_team_03 -Mdir obj_dir -f sources.f

# The simulator exits non-zero on $fatal; the log decides the result
./obj_dir/Vtb_team_03 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
